// File: all.f
+incdir+design
design/riscv_isa_pkg.sv
design/core_pipe_pkg.sv
design/stage_if.sv
design/register_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/mem_writeback_stage.sv
design/core_top.sv
verif/core_tb.sv

// File: design/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// width of registers and of the data path.
`define XLEN 32

// data memory depth in words.
`define DMEM_WORDS 64

// word address bits, log2 of DMEM_WORDS.
`define DMEM_AW 6

`endif

// File: design/core_pipe_pkg.sv
`include "core_config.svh"

package core_pipe_pkg;

    import riscv_isa_pkg::*;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_PASS_B = 3'd5
    } alu_op_e;

    // decode to execute payload.
    typedef struct packed {
        alu_op_e          alu_op;
        logic [`XLEN-1:0] operand_a;
        logic [`XLEN-1:0] operand_b;
        logic [`XLEN-1:0] store_data;
        logic [4:0]       rd;
        logic             wd;
        load_type_e       load_type;
        store_type_e      store_type;
    } dec_exe_t;

    // execute to result payload. alu_result is the byte address for memory items.
    typedef struct packed {
        logic [`XLEN-1:0] alu_result;
        logic [`XLEN-1:0] store_data;
        logic [4:0]       rd;
        logic             wd;
        load_type_e       load_type;
        store_type_e      store_type;
    } exe_res_t;

endpackage

// File: design/core_top.sv
`timescale 1ns/1ps
`include "core_config.svh"

module core_top (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             instr_valid_i,
    output logic             instr_ready_o,
    input  logic [31:0]      instr_i,
    output logic             wb_valid_o,
    output logic [4:0]       wb_reg_o,
    output logic [`XLEN-1:0] wb_data_o,
    output logic             illegal_o
);

    logic [4:0]       rs1_addr;
    logic [4:0]       rs2_addr;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic             rf_wen;
    logic [4:0]       rf_waddr;
    logic [`XLEN-1:0] rf_wdata;

    dec_exe_if dec_exe_bus ();
    exe_res_if exe_res_bus ();

    decode_stage decode_stage_inst (
        .clk           (clk),
        .rst_i         (rst_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .instr_ready_o (instr_ready_o),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .rf_wen_i      (rf_wen),
        .rf_waddr_i    (rf_waddr),
        .illegal_o     (illegal_o),
        .out           (dec_exe_bus.producer)
    );

    register_file register_file_inst (
        .clk        (clk),
        .rst_i      (rst_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wen_i      (rf_wen),
        .waddr_i    (rf_waddr),
        .wdata_i    (rf_wdata)
    );

    execute_stage execute_stage_inst (
        .clk   (clk),
        .rst_i (rst_i),
        .in    (dec_exe_bus.consumer),
        .out   (exe_res_bus.producer)
    );

    mem_writeback_stage mem_writeback_stage_inst (
        .clk        (clk),
        .rst_i      (rst_i),
        .in         (exe_res_bus.consumer),
        .wb_valid_o (rf_wen),
        .wb_reg_o   (rf_waddr),
        .wb_data_o  (rf_wdata)
    );

    // the register write port is also the visible write-back port.
    assign wb_valid_o = rf_wen;
    assign wb_reg_o   = rf_waddr;
    assign wb_data_o  = rf_wdata;

endmodule

// File: design/decode_stage.sv
`timescale 1ns/1ps
`include "core_config.svh"

module decode_stage
    import riscv_isa_pkg::*;
    import core_pipe_pkg::*;
(
    input  logic             clk,
    input  logic             rst_i,
    input  logic             instr_valid_i,
    input  logic [31:0]      instr_i,
    output logic             instr_ready_o,
    output logic [4:0]       rs1_addr_o,
    output logic [4:0]       rs2_addr_o,
    input  logic [`XLEN-1:0] rs1_data_i,
    input  logic [`XLEN-1:0] rs2_data_i,
    input  logic             rf_wen_i,
    input  logic [4:0]       rf_waddr_i,
    output logic             illegal_o,
    dec_exe_if.producer      out
);

    logic [31:0]      instr_q;
    logic             instr_vld_q;
    logic [31:0]      busy_q;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_u;
    logic             uses_rs1;
    logic             uses_rs2;
    logic             illegal;
    logic             hazard;
    logic             launch;
    dec_exe_t         dec;

    assign funct3     = instr_q[14:12];
    assign funct7     = instr_q[31:25];
    assign rs1_addr_o = instr_q[19:15];
    assign rs2_addr_o = instr_q[24:20];

    assign imm_i = {{(`XLEN-12){instr_q[31]}}, instr_q[31:20]};
    assign imm_s = {{(`XLEN-12){instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
    assign imm_u = {instr_q[31:12], 12'b0};

    // ================================================
    // instruction decode
    // ================================================
    always_comb begin
        dec            = '0;
        dec.alu_op     = ALU_ADD;
        dec.operand_a  = rs1_data_i;
        dec.operand_b  = rs2_data_i;
        dec.store_data = rs2_data_i;
        dec.rd         = instr_q[11:7];
        dec.load_type  = LD_NONE;
        dec.store_type = ST_NONE;
        uses_rs1       = 1'b0;
        uses_rs2       = 1'b0;
        illegal        = 1'b0;
        case (opcode_e'(instr_q[6:0]))
            OPC_OP: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                dec.wd   = 1'b1;
                if (funct7 == F7_BASE) begin
                    case (funct3)
                        F3_ADD_SUB: dec.alu_op = ALU_ADD;
                        F3_XOR:     dec.alu_op = ALU_XOR;
                        F3_OR:      dec.alu_op = ALU_OR;
                        F3_AND:     dec.alu_op = ALU_AND;
                        default:    illegal = 1'b1;
                    endcase
                end else if (funct7 == F7_ALT && funct3 == F3_ADD_SUB) begin
                    dec.alu_op = ALU_SUB;
                end else begin
                    illegal = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                uses_rs1      = 1'b1;
                dec.wd        = 1'b1;
                dec.operand_b = imm_i;
                illegal       = (funct3 != F3_ADD_SUB);
            end
            OPC_LUI: begin
                dec.wd        = 1'b1;
                dec.alu_op    = ALU_PASS_B;
                dec.operand_b = imm_u;
            end
            OPC_LOAD: begin
                uses_rs1      = 1'b1;
                dec.wd        = 1'b1;
                dec.operand_b = imm_i;
                case (funct3)
                    3'b000:  dec.load_type = LD_LB;
                    3'b001:  dec.load_type = LD_LH;
                    3'b010:  dec.load_type = LD_LW;
                    3'b100:  dec.load_type = LD_LBU;
                    3'b101:  dec.load_type = LD_LHU;
                    default: illegal = 1'b1;
                endcase
            end
            OPC_STORE: begin
                uses_rs1      = 1'b1;
                uses_rs2      = 1'b1;
                dec.operand_b = imm_s;
                case (funct3)
                    3'b000:  dec.store_type = ST_SB;
                    3'b001:  dec.store_type = ST_SH;
                    3'b010:  dec.store_type = ST_SW;
                    default: illegal = 1'b1;
                endcase
            end
            default: illegal = 1'b1;
        endcase
    end

    // ================================================
    // scoreboard and launch
    // ================================================
    // a busy destination also stalls, so an older write cannot clear a younger one's bit.
    assign hazard = (uses_rs1 && busy_q[rs1_addr_o]) ||
                    (uses_rs2 && busy_q[rs2_addr_o]) ||
                    (dec.wd && busy_q[dec.rd]);
    assign launch        = instr_vld_q && !illegal && !hazard;
    assign instr_ready_o = !instr_vld_q || illegal || !hazard;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            instr_vld_q <= 1'b0;
        end else if (instr_ready_o) begin
            instr_vld_q <= instr_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_ready_o && instr_valid_i) begin
            instr_q <= instr_i;
        end
    end

    // set wins over clear when the same register retires and is claimed again.
    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy_q <= '0;
        end else begin
            if (rf_wen_i) begin
                busy_q[rf_waddr_i] <= 1'b0;
            end
            if (launch && dec.wd && dec.rd != 5'd0) begin
                busy_q[dec.rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            out.valid <= 1'b0;
            illegal_o <= 1'b0;
        end else begin
            out.valid <= launch;
            illegal_o <= instr_vld_q && illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            out.payload <= dec;
        end
    end

    // a launch never reads the destination of the item in execute, whose write-back is ahead.
    assert property (@(posedge clk) disable iff (rst_i)
        launch && out.valid && out.payload.wd && out.payload.rd != 5'd0 |->
            !(uses_rs1 && rs1_addr_o == out.payload.rd) &&
            !(uses_rs2 && rs2_addr_o == out.payload.rd));

endmodule

// File: design/execute_stage.sv
`timescale 1ns/1ps
`include "core_config.svh"

module execute_stage
    import core_pipe_pkg::*;
(
    input  logic        clk,
    input  logic        rst_i,
    dec_exe_if.consumer in,
    exe_res_if.producer out
);

    logic [`XLEN-1:0] alu_result;

    // loads and stores use ALU_ADD, which gives the byte address.
    always_comb begin
        case (in.payload.alu_op)
            ALU_ADD:    alu_result = in.payload.operand_a + in.payload.operand_b;
            ALU_SUB:    alu_result = in.payload.operand_a - in.payload.operand_b;
            ALU_AND:    alu_result = in.payload.operand_a & in.payload.operand_b;
            ALU_OR:     alu_result = in.payload.operand_a | in.payload.operand_b;
            ALU_XOR:    alu_result = in.payload.operand_a ^ in.payload.operand_b;
            ALU_PASS_B: alu_result = in.payload.operand_b;
            default:    alu_result = in.payload.operand_a + in.payload.operand_b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid) begin
            out.payload.alu_result <= alu_result;
            out.payload.store_data <= in.payload.store_data;
            out.payload.rd         <= in.payload.rd;
            out.payload.wd         <= in.payload.wd;
            out.payload.load_type  <= in.payload.load_type;
            out.payload.store_type <= in.payload.store_type;
        end
    end

endmodule

// File: design/mem_writeback_stage.sv
`timescale 1ns/1ps
`include "core_config.svh"

module mem_writeback_stage
    import riscv_isa_pkg::*;
(
    input  logic             clk,
    input  logic             rst_i,
    exe_res_if.consumer      in,
    output logic             wb_valid_o,
    output logic [4:0]       wb_reg_o,
    output logic [`XLEN-1:0] wb_data_o
);

    logic [`XLEN-1:0]    dmem [`DMEM_WORDS];
    logic [`DMEM_AW-1:0] word_idx;
    logic [1:0]          byte_off;
    logic [3:0]          wmask;
    logic [`XLEN-1:0]    wdata;
    logic [`XLEN-1:0]    rword;
    logic [15:0]         rhalf;
    logic [7:0]          rbyte;
    logic [`XLEN-1:0]    load_data;
    logic                is_load;
    logic                is_store;

    // addresses wrap inside the memory. misalignment is not checked.
    assign word_idx = in.payload.alu_result[`DMEM_AW+1:2];
    assign byte_off = in.payload.alu_result[1:0];
    assign is_load  = (in.payload.load_type != LD_NONE);
    assign is_store = (in.payload.store_type != ST_NONE);

    // ================================================
    // store path
    // ================================================
    always_comb begin
        case (in.payload.store_type)
            ST_SB: begin
                wmask = 4'b0001 << byte_off;
                wdata = {4{in.payload.store_data[7:0]}};
            end
            ST_SH: begin
                wmask = byte_off[1] ? 4'b1100 : 4'b0011;
                wdata = {2{in.payload.store_data[15:0]}};
            end
            ST_SW: begin
                wmask = 4'b1111;
                wdata = in.payload.store_data;
            end
            default: begin
                wmask = 4'b0000;
                wdata = in.payload.store_data;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (in.valid && is_store) begin
            for (int i = 0; i < 4; i++) begin
                if (wmask[i]) begin
                    dmem[word_idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // ================================================
    // load path
    // ================================================
    assign rword = dmem[word_idx];
    assign rhalf = byte_off[1] ? rword[31:16] : rword[15:0];

    always_comb begin
        case (byte_off)
            2'd0:    rbyte = rword[7:0];
            2'd1:    rbyte = rword[15:8];
            2'd2:    rbyte = rword[23:16];
            default: rbyte = rword[31:24];
        endcase
    end

    always_comb begin
        case (in.payload.load_type)
            LD_LB:   load_data = {{(`XLEN-8){rbyte[7]}}, rbyte};
            LD_LH:   load_data = {{(`XLEN-16){rhalf[15]}}, rhalf};
            LD_LBU:  load_data = {{(`XLEN-8){1'b0}}, rbyte};
            LD_LHU:  load_data = {{(`XLEN-16){1'b0}}, rhalf};
            default: load_data = rword;
        endcase
    end

    // write-back register. x0 and stores never raise valid.
    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= in.valid && in.payload.wd && (in.payload.rd != 5'd0);
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid) begin
            wb_reg_o  <= in.payload.rd;
            wb_data_o <= is_load ? load_data : in.payload.alu_result;
        end
    end

    // decode never builds an item that both loads and stores, or a store with write-back.
    assert property (@(posedge clk) disable iff (rst_i)
        in.valid |-> !(is_load && is_store) && !(is_store && in.payload.wd));

endmodule

// File: design/register_file.sv
`timescale 1ns/1ps
`include "core_config.svh"

module register_file (
    input  logic             clk,
    input  logic             rst_i,
    input  logic [4:0]       rs1_addr_i,
    input  logic [4:0]       rs2_addr_i,
    output logic [`XLEN-1:0] rs1_data_o,
    output logic [`XLEN-1:0] rs2_data_o,
    input  logic             wen_i,
    input  logic [4:0]       waddr_i,
    input  logic [`XLEN-1:0] wdata_i
);

    logic [`XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i && waddr_i != 5'd0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // x0 is hardwired to zero.
    assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 : regs[rs2_addr_i];

    // the result stage filters rd == 0 before it ever reaches the write port.
    assert property (@(posedge clk) disable iff (rst_i)
        wen_i |-> waddr_i != 5'd0);

endmodule

// File: design/riscv_isa_pkg.sv
package riscv_isa_pkg;

    // ================================================
    // major opcodes of the supported RV32I subset
    // ================================================
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    // a nonzero load type marks the item as a load.
    typedef enum logic [2:0] {
        LD_NONE = 3'd0,
        LD_LB   = 3'd1,
        LD_LH   = 3'd2,
        LD_LW   = 3'd3,
        LD_LBU  = 3'd4,
        LD_LHU  = 3'd5
    } load_type_e;

    typedef enum logic [1:0] {
        ST_NONE = 2'd0,
        ST_SB   = 2'd1,
        ST_SH   = 2'd2,
        ST_SW   = 2'd3
    } store_type_e;

    // funct3 and funct7 codes used for register and immediate arithmetic.
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;

endpackage

// File: design/stage_if.sv
`timescale 1ns/1ps

// decode to execute link. execute never stalls, so there is no ready.
interface dec_exe_if
    import core_pipe_pkg::*;
();

    logic     valid;
    dec_exe_t payload;

    modport producer (
        output valid,
        output payload
    );

    modport consumer (
        input valid,
        input payload
    );

endinterface

// execute to result link.
interface exe_res_if
    import core_pipe_pkg::*;
();

    logic     valid;
    exe_res_t payload;

    modport producer (
        output valid,
        output payload
    );

    modport consumer (
        input valid,
        input payload
    );

endinterface

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the core testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module core_tb \
    -f all.f \
    -o core_sim

./obj_dir/core_sim | tee sim.log

if grep -qx "ALL CHECKS PASSED" sim.log; then
    exit 0
else
    echo "simulation did not pass, see sim.log"
    exit 1
fi

// File: verif/core_tb.sv
`timescale 1ns/1ps
`include "core_config.svh"

module core_tb
    import riscv_isa_pkg::*;
();

    localparam int          NUM_INSTR      = 400;
    localparam int          INIT_WORDS     = 16;
    localparam logic [31:0] TIMEOUT_CYCLES = NUM_INSTR * 8 + 100;
    localparam logic [31:0] LFSR_SEED      = 32'h3bba0238;

    localparam int K_ADD     = 0;
    localparam int K_SUB     = 1;
    localparam int K_AND     = 2;
    localparam int K_OR      = 3;
    localparam int K_XOR     = 4;
    localparam int K_ADDI    = 5;
    localparam int K_LUI     = 6;
    localparam int K_LB      = 7;
    localparam int K_LH      = 8;
    localparam int K_LW      = 9;
    localparam int K_LBU     = 10;
    localparam int K_LHU     = 11;
    localparam int K_SB      = 12;
    localparam int K_SH      = 13;
    localparam int K_SW      = 14;
    localparam int K_ILLEGAL = 15;

    logic             clk = 1'b0;
    logic             rst_i;
    logic             instr_valid_i;
    logic             instr_ready_o;
    logic [31:0]      instr_i;
    logic             wb_valid_o;
    logic [4:0]       wb_reg_o;
    logic [`XLEN-1:0] wb_data_o;
    logic             illegal_o;

    logic [31:0]      lfsr;
    logic [`XLEN-1:0] model_regs [32];
    logic [7:0]       model_mem [256];

    // expected write-backs in acceptance order.
    logic [4:0]       exp_reg [1024];
    logic [`XLEN-1:0] exp_data [1024];
    logic [31:0]      exp_cycle [1024];
    logic             exp_fast [1024];
    logic [9:0]       rd_ptr;
    logic [9:0]       wr_ptr;
    logic             exp_pending;
    logic [4:0]       head_reg;
    logic [`XLEN-1:0] head_data;
    logic [31:0]      head_cycle;
    logic             head_fast;

    logic [31:0]      cycle_count = '0;
    logic             wb_seen;
    int               value_errors = 0;
    int               protocol_errors = 0;
    int               illegal_errors = 0;
    int               illegal_sent = 0;
    int               illegal_seen = 0;

    core_top core_top_inst (
        .clk           (clk),
        .rst_i         (rst_i),
        .instr_valid_i (instr_valid_i),
        .instr_ready_o (instr_ready_o),
        .instr_i       (instr_i),
        .wb_valid_o    (wb_valid_o),
        .wb_reg_o      (wb_reg_o),
        .wb_data_o     (wb_data_o),
        .illegal_o     (illegal_o)
    );

    always #4 clk = ~clk;

    assign exp_pending = (rd_ptr != wr_ptr);
    assign head_reg    = exp_reg[rd_ptr];
    assign head_data   = exp_data[rd_ptr];
    assign head_cycle  = exp_cycle[rd_ptr];
    assign head_fast   = exp_fast[rd_ptr];

    // ================================================
    // monitors and checking assertions
    // ================================================
    // outputs are captured mid-cycle, where they are stable.
    always @(negedge clk) begin
        wb_seen <= wb_valid_o;
        if (!rst_i && illegal_o) begin
            illegal_seen = illegal_seen + 1;
        end
    end

    always @(posedge clk) begin
        if (rst_i) begin
            rd_ptr <= '0;
        end else if (wb_seen) begin
            rd_ptr <= rd_ptr + 10'd1;
        end
    end

    assert property (@(posedge clk) $fell(rst_i) |-> !wb_valid_o && !illegal_o && instr_ready_o)
        else begin
            $display("CHECK FAILED reset state wb_valid_o %h illegal_o %h instr_ready_o %h",
                     $sampled(wb_valid_o), $sampled(illegal_o), $sampled(instr_ready_o));
            protocol_errors = protocol_errors + 1;
        end

    assert property (@(posedge clk) disable iff (rst_i) wb_valid_o |-> exp_pending)
        else begin
            $display("write-back pulse arrived while no write-back was outstanding");
            protocol_errors = protocol_errors + 1;
        end

    assert property (@(posedge clk) disable iff (rst_i)
        wb_valid_o && exp_pending |-> wb_reg_o == head_reg)
        else begin
            $display("CHECK FAILED wb_reg_o expected %h actual %h",
                     $sampled(head_reg), $sampled(wb_reg_o));
            value_errors = value_errors + 1;
        end

    assert property (@(posedge clk) disable iff (rst_i)
        wb_valid_o && exp_pending |-> wb_data_o == head_data)
        else begin
            $display("CHECK FAILED wb_data_o expected %h actual %h",
                     $sampled(head_data), $sampled(wb_data_o));
            value_errors = value_errors + 1;
        end

    // an instruction that met no busy register retires three edges after acceptance.
    assert property (@(posedge clk) disable iff (rst_i)
        wb_valid_o && exp_pending && head_fast |-> cycle_count == head_cycle + 32'd3)
        else begin
            $display("CHECK FAILED wb_valid_o latency expected %h actual %h",
                     32'd3, $sampled(cycle_count) - $sampled(head_cycle));
            value_errors = value_errors + 1;
        end

    task automatic print_error_counts();
        $display("errors: value %0d, protocol %0d, illegal %0d (illegal sent %0d, seen %0d)",
                 value_errors, protocol_errors, illegal_errors, illegal_sent, illegal_seen);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 32'd1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d write-backs still outstanding",
                     cycle_count, wr_ptr - rd_ptr);
            print_error_counts();
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // ================================================
    // stimulus helpers
    // ================================================
    // taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    // returns at the negedge before the handshake edge.
    task automatic send(input logic [31:0] word);
        @(posedge clk);
        #1;
        instr_valid_i = 1'b1;
        instr_i       = word;
        @(negedge clk);
        while (!instr_ready_o) begin
            @(negedge clk);
        end
    endtask

    task automatic do_instr(input int kind, input logic [4:0] rd, input logic [4:0] rs1,
                            input logic [4:0] rs2, input logic [31:0] imm);
        logic [31:0]      word;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] res;
        logic [`XLEN-1:0] imm_x;
        logic [`XLEN-1:0] addr_full;
        logic [7:0]       addr;
        logic             writes;
        logic             uses1;
        logic             uses2;
        logic             fast;
        logic [9:0]       p;
        uses1 = (kind != K_LUI);
        uses2 = (kind <= K_XOR) || (kind >= K_SB && kind <= K_SW);
        case (kind)
            K_ADD:  word = enc_r(7'b0000000, rs2, rs1, 3'b000, rd);
            K_SUB:  word = enc_r(7'b0100000, rs2, rs1, 3'b000, rd);
            K_AND:  word = enc_r(7'b0000000, rs2, rs1, 3'b111, rd);
            K_OR:   word = enc_r(7'b0000000, rs2, rs1, 3'b110, rd);
            K_XOR:  word = enc_r(7'b0000000, rs2, rs1, 3'b100, rd);
            K_ADDI: word = enc_i(imm[11:0], rs1, 3'b000, rd, OPC_OP_IMM);
            K_LUI:  word = {imm[19:0], rd, OPC_LUI};
            K_LB:   word = enc_i(imm[11:0], rs1, 3'b000, rd, OPC_LOAD);
            K_LH:   word = enc_i(imm[11:0], rs1, 3'b001, rd, OPC_LOAD);
            K_LW:   word = enc_i(imm[11:0], rs1, 3'b010, rd, OPC_LOAD);
            K_LBU:  word = enc_i(imm[11:0], rs1, 3'b100, rd, OPC_LOAD);
            K_LHU:  word = enc_i(imm[11:0], rs1, 3'b101, rd, OPC_LOAD);
            K_SB:   word = enc_s(imm[11:0], rs2, rs1, 3'b000);
            K_SH:   word = enc_s(imm[11:0], rs2, rs1, 3'b001);
            K_SW:   word = enc_s(imm[11:0], rs2, rs1, 3'b010);
            default: begin
                // shift, shift-immediate, jump and a reserved load width.
                case (imm[1:0])
                    2'd0:    word = enc_r(7'b0000000, rs2, rs1, 3'b001, rd);
                    2'd1:    word = enc_i(12'h005, rs1, 3'b101, rd, OPC_OP_IMM);
                    2'd2:    word = {20'h0, rd, 7'b1101111};
                    default: word = enc_i(imm[11:0], rs1, 3'b011, rd, OPC_LOAD);
                endcase
            end
        endcase

        send(word);

        a         = model_regs[rs1];
        b         = model_regs[rs2];
        imm_x     = {{(`XLEN-12){imm[11]}}, imm[11:0]};
        addr_full = a + imm_x;
        addr      = addr_full[7:0];
        writes    = (kind <= K_LHU);
        res       = '0;
        case (kind)
            K_ADD:  res = a + b;
            K_SUB:  res = a - b;
            K_AND:  res = a & b;
            K_OR:   res = a | b;
            K_XOR:  res = a ^ b;
            K_ADDI: res = a + imm_x;
            K_LUI:  res = {imm[19:0], 12'h000};
            K_LB:   res = {{(`XLEN-8){model_mem[addr][7]}}, model_mem[addr]};
            K_LH: begin
                res = {{(`XLEN-16){model_mem[addr + 8'd1][7]}},
                       model_mem[addr + 8'd1], model_mem[addr]};
            end
            K_LW: begin
                res = {model_mem[addr + 8'd3], model_mem[addr + 8'd2],
                       model_mem[addr + 8'd1], model_mem[addr]};
            end
            K_LBU:  res = {{(`XLEN-8){1'b0}}, model_mem[addr]};
            K_LHU:  res = {{(`XLEN-16){1'b0}}, model_mem[addr + 8'd1], model_mem[addr]};
            K_SB:   model_mem[addr] = b[7:0];
            K_SH: begin
                model_mem[addr]        = b[7:0];
                model_mem[addr + 8'd1] = b[15:8];
            end
            K_SW: begin
                model_mem[addr]        = b[7:0];
                model_mem[addr + 8'd1] = b[15:8];
                model_mem[addr + 8'd2] = b[23:16];
                model_mem[addr + 8'd3] = b[31:24];
            end
            default: illegal_sent = illegal_sent + 1;
        endcase

        // any outstanding write to a register this one touches may stall decode.
        fast = 1'b1;
        for (p = rd_ptr; p != wr_ptr; p = p + 10'd1) begin
            if ((uses1 && exp_reg[p] == rs1) || (uses2 && exp_reg[p] == rs2) ||
                exp_reg[p] == rd) begin
                fast = 1'b0;
            end
        end

        if (writes && rd != 5'd0) begin
            model_regs[rd]    = res;
            exp_reg[wr_ptr]   = rd;
            exp_data[wr_ptr]  = res;
            // the cycle count as it stands once the handshake edge has passed.
            exp_cycle[wr_ptr] = cycle_count + 32'd1;
            exp_fast[wr_ptr]  = fast;
            wr_ptr            = wr_ptr + 10'd1;
        end
    endtask

    // loads and stores use base x0 and aligned offsets below 64.
    task automatic issue_random();
        logic [31:0] r;
        logic [31:0] imm;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        int          kind;
        take_bits(5, r);
        kind = (r[4:0] >= 5'd30) ? K_ILLEGAL : int'(r[4:0]) % 15;
        take_bits(3, r);
        rd = {2'b00, r[2:0]};
        take_bits(3, r);
        rs1 = {2'b00, r[2:0]};
        take_bits(3, r);
        rs2 = {2'b00, r[2:0]};
        case (kind)
            K_LUI:              take_bits(20, imm);
            K_LB, K_LBU, K_SB:  take_bits(6, imm);
            K_LH, K_LHU, K_SH: begin
                take_bits(5, imm);
                imm = imm << 1;
            end
            K_LW, K_SW: begin
                take_bits(4, imm);
                imm = imm << 2;
            end
            default:            take_bits(12, imm);
        endcase
        if (kind >= K_LB && kind <= K_SW) begin
            rs1 = 5'd0;
        end
        do_instr(kind, rd, rs1, rs2, imm);
    endtask

    // ================================================
    // main sequence
    // ================================================
    initial begin
        logic [31:0] r;
        rst_i         = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        lfsr          = LFSR_SEED;
        wr_ptr        = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (10) @(posedge clk);
        #1;
        rst_i = 1'b0;

        // fill every word that the random loads can reach.
        for (int w = 0; w < INIT_WORDS; w++) begin
            take_bits(20, r);
            do_instr(K_LUI, 5'd1, 5'd0, 5'd0, r);
            take_bits(12, r);
            do_instr(K_ADDI, 5'd1, 5'd1, 5'd0, r);
            do_instr(K_SW, 5'd0, 5'd0, 5'd1, 32'(w * 4));
        end

        for (int n = 0; n < NUM_INSTR - 3 * INIT_WORDS; n++) begin
            take_bits(3, r);
            if (r[2:0] == 3'd0) begin
                @(posedge clk);
                #1;
                instr_valid_i = 1'b0;
                repeat (3) @(posedge clk);
            end
            issue_random();
        end

        @(posedge clk);
        #1;
        instr_valid_i = 1'b0;
        while (rd_ptr != wr_ptr) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);

        assert (illegal_seen == illegal_sent)
            else begin
                $display("CHECK FAILED illegal_o pulses expected %h actual %h",
                         illegal_sent, illegal_seen);
                illegal_errors = illegal_errors + 1;
            end

        print_error_counts();
        if (value_errors == 0 && protocol_errors == 0 && illegal_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
